// ==== verilog/dfc_params.svh ====
// Build-time sizing for the delayed-flow-control receiver.
// Include wherever a width, depth or threshold is needed.
`ifndef DFC_PARAMS_SVH
`define DFC_PARAMS_SVH

// Link payload width in bits
`define DFC_WIDTH 16

// Round trip from c_fc_n leaving the receiver back to c_vld
`define DFC_RT_LAT 4

// Occupancy at which the go signal is withdrawn
`define DFC_THD 2

// Words in flight plus threshold plus the c_fc_n register stage
`define DFC_DEPTH (`DFC_RT_LAT + `DFC_THD + 2)

// Usage readback field, saturates at all ones
`define DFC_USAGE_W 3

`endif

// ==== verilog/dfc_pkg.sv ====
// Types and register map shared by the receiver blocks and the testbench.
// Referenced by scoped name only.
`include "dfc_params.svh"

package dfc_pkg;

    // ------------------------------
    // Data types
    // ------------------------------

    // One word as carried on the link
    typedef logic [`DFC_WIDTH-1:0] dfc_word_t;

    // FIFO fill level, holds 0 through DFC_DEPTH inclusive
    typedef logic [$clog2(`DFC_DEPTH + 1)-1:0] dfc_occ_t;

    // ------------------------------
    // APB register map
    // ------------------------------

    // Force-stop control, bit 0
    localparam logic [7:0] ADDR_CTRL   = 8'h00;
    // Sticky overflow, write 1 to clear
    localparam logic [7:0] ADDR_STATUS = 8'h04;
    // Saturated FIFO occupancy, read only
    localparam logic [7:0] ADDR_USAGE  = 8'h08;

endpackage

// ==== verilog/dfc_fifo_wr_if.sv ====
// Write side of the receive FIFO.
// The control block pushes link words; the FIFO returns full and fill level.
`timescale 1ns/1ps

interface dfc_fifo_wr_if #(
    parameter type payload_t = dfc_pkg::dfc_word_t
);

    // Write strobe for one word per edge
    logic               push;
    payload_t           data;
    // No room left so push must stay low
    logic               full;
    // Current number of queued words
    dfc_pkg::dfc_occ_t  occ;

    modport ctl (
        output push,
        output data,
        input  full,
        input  occ
    );

    modport fifo (
        input  push,
        input  data,
        output full,
        output occ
    );

endinterface

// ==== verilog/dfc_rx_ctl.sv ====
// Link acceptance for the delayed-flow-control receiver.
// Pushes valid link words into the FIFO, flags words that find it full,
// and drives the registered c_fc_n go signal from projected occupancy.
`timescale 1ns/1ps
`include "dfc_params.svh"

module dfc_rx_ctl (
    input  logic               clk,
    input  logic               rst,
    // Link side
    input  logic               c_vld,
    input  dfc_pkg::dfc_word_t c_data,
    output logic               c_fc_n,
    // Software override and status
    input  logic               force_stop,
    output logic               overflow_pulse,
    // FIFO write side
    dfc_fifo_wr_if.ctl         wr,
    input  logic               pop
);

    dfc_pkg::dfc_occ_t next_occ;
    logic              fc_go;

    // ------------------------------
    // Write path
    // ------------------------------

    // Link input is not flopped, words go straight to the FIFO
    assign wr.data = c_data;

    // Only write while there is room
    assign wr.push = c_vld && !wr.full;

    // ------------------------------
    // Flow control
    // ------------------------------

    // Occupancy as it will be after this edge
    always_comb begin
        next_occ = wr.occ + dfc_pkg::dfc_occ_t'(wr.push) - dfc_pkg::dfc_occ_t'(pop);
    end

    // Go only below threshold and without software hold
    assign fc_go = (next_occ < `DFC_THD) && !force_stop;

    always_ff @(posedge clk) begin
        if (rst) begin
            c_fc_n         <= 1'b0;
            overflow_pulse <= 1'b0;
        end else begin
            c_fc_n         <= fc_go;
            // Word arrived with nowhere to go
            overflow_pulse <= c_vld && wr.full;
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------

    // FIFO full state must block every write
    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (rst) !(wr.push && wr.full)
    );

    // Transmitter is held off through reset
    a_fc_low_after_rst: assert property (
        @(posedge clk) rst |=> !c_fc_n
    );

endmodule

// ==== verilog/dfc_rx_fifo.sv ====
// Synchronous receive FIFO with fill-level count.
// Write side comes through the FIFO modport; read side is a
// srdy/drdy consumer port. Payload type and depth are parameters.
`timescale 1ns/1ps

module dfc_rx_fifo #(
    parameter type payload_t = dfc_pkg::dfc_word_t,
    parameter int  depth     = 8
) (
    input  logic              clk,
    input  logic              rst,
    // Write side from the control block
    dfc_fifo_wr_if.fifo       wr,
    // Consumer side
    output logic              p_srdy,
    input  logic              p_drdy,
    output payload_t          p_data,
    output logic              pop,
    output dfc_pkg::dfc_occ_t occ_out
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

    payload_t          mem [depth];
    logic [ptr_w-1:0]  wr_ptr;
    logic [ptr_w-1:0]  rd_ptr;
    dfc_pkg::dfc_occ_t occ;

    // Pointer advance with wrap for any depth
    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // ------------------------------
    // Storage
    // ------------------------------

    // No reset on payload
    always_ff @(posedge clk) begin
        if (wr.push) begin
            mem[wr_ptr] <= wr.data;
        end
    end

    // ------------------------------
    // Pointers and count
    // ------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            occ    <= '0;
        end else begin
            if (wr.push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            // Simultaneous push and pop leaves the count alone
            case ({wr.push, pop})
                2'b10:   occ <= occ + 1'b1;
                2'b01:   occ <= occ - 1'b1;
                default: occ <= occ;
            endcase
        end
    end

    // Status back to control and CSR
    assign wr.full = (occ == dfc_pkg::dfc_occ_t'(depth));
    assign wr.occ  = occ;
    assign occ_out = occ;

    // Head of queue is always presented
    assign p_srdy = (occ != '0);
    assign p_data = mem[rd_ptr];
    assign pop    = p_srdy && p_drdy;

    // Count must stay within storage
    a_occ_in_range: assert property (
        @(posedge clk) disable iff (rst) occ <= dfc_pkg::dfc_occ_t'(depth)
    );

endmodule

// ==== verilog/dfc_rx_csr.sv ====
// APB register block for the receiver.
// CTRL holds the force-stop override, STATUS the sticky overflow flag,
// USAGE the saturated FIFO fill level. Zero-wait, no wait states.
`timescale 1ns/1ps
`include "dfc_params.svh"

module dfc_rx_csr (
    input  logic              clk,
    input  logic              rst,
    // APB slave
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [7:0]        paddr,
    input  logic [31:0]       pwdata,
    output logic [31:0]       prdata,
    output logic              pready,
    output logic              pslverr,
    // Receiver side
    output logic              force_stop,
    input  logic              overflow_pulse,
    input  dfc_pkg::dfc_occ_t occ
);

    localparam int usage_max = (1 << `DFC_USAGE_W) - 1;

    logic                    access;
    logic                    hit_ctrl;
    logic                    hit_status;
    logic                    hit_usage;
    logic                    ovf_sticky;
    logic [`DFC_USAGE_W-1:0] usage;

    // ------------------------------
    // Decode
    // ------------------------------

    assign access     = psel && penable;
    assign hit_ctrl   = (paddr == dfc_pkg::ADDR_CTRL);
    assign hit_status = (paddr == dfc_pkg::ADDR_STATUS);
    assign hit_usage  = (paddr == dfc_pkg::ADDR_USAGE);

    // Always ready
    assign pready  = 1'b1;
    assign pslverr = access && !(hit_ctrl || hit_status || hit_usage);

    // ------------------------------
    // Registers
    // ------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            force_stop <= 1'b0;
            ovf_sticky <= 1'b0;
        end else begin
            if (access && pwrite && hit_ctrl) begin
                force_stop <= pwdata[0];
            end
            // New overflow beats a clear in the same cycle
            if (overflow_pulse) begin
                ovf_sticky <= 1'b1;
            end else if (access && pwrite && hit_status && pwdata[0]) begin
                ovf_sticky <= 1'b0;
            end
        end
    end

    // Clamp fill level to field width
    assign usage = (int'(occ) > usage_max) ? `DFC_USAGE_W'(usage_max)
                                            : occ[`DFC_USAGE_W-1:0];

    // Read mux, unmapped reads give zero
    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            if (hit_ctrl) begin
                prdata[0] = force_stop;
            end else if (hit_status) begin
                prdata[0] = ovf_sticky;
            end else if (hit_usage) begin
                prdata[`DFC_USAGE_W-1:0] = usage;
            end
        end
    end

    // Error only in the access phase of a transfer
    a_slverr_in_access: assert property (
        @(posedge clk) disable iff (rst) pslverr |-> (psel && penable)
    );

endmodule

// ==== verilog/dfc_rx_top.sv ====
// Receive side of the delayed-flow-control link.
// Link words in on c_vld/c_data, flow control out on c_fc_n,
// words out on the srdy/drdy consumer port, configuration over APB.
`timescale 1ns/1ps
`include "dfc_params.svh"

module dfc_rx_top (
    input  logic               clk,
    input  logic               rst,
    // Link
    input  logic               c_vld,
    input  dfc_pkg::dfc_word_t c_data,
    output logic               c_fc_n,
    // Consumer
    output logic               p_srdy,
    input  logic               p_drdy,
    output dfc_pkg::dfc_word_t p_data,
    // APB
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [7:0]         paddr,
    input  logic [31:0]        pwdata,
    output logic [31:0]        prdata,
    output logic               pready,
    output logic               pslverr
);

    logic              force_stop;
    logic              overflow_pulse;
    logic              pop;
    dfc_pkg::dfc_occ_t occ;

    // Write channel between control and FIFO
    dfc_fifo_wr_if #(.payload_t(dfc_pkg::dfc_word_t)) wr_if ();

    dfc_rx_ctl i_ctl (
        .clk            (clk),
        .rst            (rst),
        .c_vld          (c_vld),
        .c_data         (c_data),
        .c_fc_n         (c_fc_n),
        .force_stop     (force_stop),
        .overflow_pulse (overflow_pulse),
        .wr             (wr_if.ctl),
        .pop            (pop)
    );

    dfc_rx_fifo #(
        .payload_t (dfc_pkg::dfc_word_t),
        .depth     (`DFC_DEPTH)
    ) i_fifo (
        .clk     (clk),
        .rst     (rst),
        .wr      (wr_if.fifo),
        .p_srdy  (p_srdy),
        .p_drdy  (p_drdy),
        .p_data  (p_data),
        .pop     (pop),
        .occ_out (occ)
    );

    dfc_rx_csr i_csr (
        .clk            (clk),
        .rst            (rst),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .paddr          (paddr),
        .pwdata         (pwdata),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr),
        .force_stop     (force_stop),
        .overflow_pulse (overflow_pulse),
        .occ            (occ)
    );

endmodule

// ==== dv/dfc_rx_tests.svh ====
// Register access helpers and directed tests for the receiver testbench.
// Included inside the testbench module, so DUT and model signals are in scope.
`ifndef DFC_RX_TESTS_SVH
`define DFC_RX_TESTS_SVH

    localparam int wait_limit = 4000;
    localparam int usage_max  = (1 << `DFC_USAGE_W) - 1;

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    // Sample point 2 ns after the edge where models and DUT have settled
    task automatic settle(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    function automatic bit state_reached(input string what);
        if (what == "drained") return tx_remaining == 0 && exp_q.size() == 0;
        if (what == "tx_done") return tx_remaining == 0;
        if (what == "fc_low") return c_fc_n === 1'b0;
        if (what == "busy") return exp_q.size() != 0;
        if (what == "empty") return exp_q.size() == 0 && p_srdy === 1'b0;
        return 1'b0;
    endfunction

    task automatic wait_state(input string what);
        int n = 0;
        settle(1);
        while (!state_reached(what) && n < wait_limit) begin
            settle(1);
            n++;
        end
        if (!state_reached(what)) begin
            $display("Timed out waiting for state %s at %0t", what, $time);
            err_count++;
        end
    endtask

    // Model knobs change only at the sample point
    task automatic set_models(input int pct, input bit ign, input int words);
        settle(1);
        drdy_pct     = pct;
        ignore_fc    = ign;
        tx_remaining = tx_remaining + words;
    endtask

    // ------------------------------
    // APB access
    // ------------------------------

    // Setup then access phase and return 1 ns after the access edge
    task automatic bus_transfer(input bit wr, input logic [7:0] addr,
                                input logic [31:0] wdata,
                                output logic [31:0] rdata, output logic err);
        int n = 0;
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        while (pready !== 1'b1 && n < 16) begin
            @(negedge clk);
            n++;
        end
        if (pready !== 1'b1) begin
            $display("No pready for address %h at %0t", addr, $time);
            err_count++;
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] rd;
        logic        err;
        bus_transfer(1'b1, addr, data, rd, err);
        check_eq("pslverr", err, 0);
    endtask

    task automatic expect_reg(input string name, input logic [7:0] addr,
                              input logic [31:0] exp);
        logic [31:0] rd;
        logic        err;
        bus_transfer(1'b0, addr, '0, rd, err);
        check_eq("pslverr", err, 0);
        check_eq(name, rd, exp);
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (err_count == errs_before) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, err_count - errs_before);
        end
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------

    task automatic reset_state_check();
        int errs = err_count;
        repeat (4) begin
            @(posedge clk);
            #1;
            check_eq("c_fc_n", c_fc_n, 0);
        end
        rst = 1'b0;
        // Go rises on the first edge out of reset
        @(posedge clk);
        #1;
        check_eq("c_fc_n", c_fc_n, 1);
        check_eq("p_srdy", p_srdy, 0);
        expect_reg("ctrl", dfc_pkg::ADDR_CTRL, 0);
        expect_reg("status", dfc_pkg::ADDR_STATUS, 0);
        expect_reg("usage", dfc_pkg::ADDR_USAGE, 0);
        report_test("reset state", errs);
    endtask

    task automatic stream_backpressure();
        int errs = err_count;
        int rcv_start = rcv_count;
        set_models(50, 1'b0, 200);
        wait_state("drained");
        check_eq("words received", rcv_count - rcv_start, 200);
        // Depth covers threshold plus round trip
        expect_reg("status", dfc_pkg::ADDR_STATUS, 0);
        set_models(100, 1'b0, 0);
        report_test("streaming under back-pressure", errs);
    endtask

    task automatic threshold_flow();
        int errs = err_count;
        int sent_start = tx_sent;
        int sent;
        set_models(0, 1'b0, 20);
        wait_state("fc_low");
        // Words already in flight land within the round trip
        settle(`DFC_RT_LAT + 2);
        sent = tx_sent - sent_start;
        assert (sent >= `DFC_THD && sent <= `DFC_DEPTH) else begin
            $display("Link sent %0d words before it stopped", sent);
            err_count++;
        end
        expect_reg("usage", dfc_pkg::ADDR_USAGE, (sent > usage_max) ? usage_max : sent);
        check_eq("c_fc_n", c_fc_n, 0);
        set_models(100, 1'b0, 0);
        wait_state("drained");
        settle(1);
        check_eq("c_fc_n", c_fc_n, 1);
        expect_reg("status", dfc_pkg::ADDR_STATUS, 0);
        report_test("threshold flow control", errs);
    endtask

    task automatic force_stop_hold();
        int errs = err_count;
        set_models(100, 1'b0, 40);
        wait_state("busy");
        settle(3);
        write_reg(dfc_pkg::ADDR_CTRL, 1);
        // CSR edge and then the registered go
        @(posedge clk);
        #2;
        check_eq("c_fc_n", c_fc_n, 0);
        wait_state("empty");
        // Link still held off with an empty FIFO
        repeat (`DFC_RT_LAT + 4) begin
            settle(1);
            check_eq("c_fc_n", c_fc_n, 0);
            check_eq("c_vld", c_vld, 0);
        end
        expect_reg("ctrl", dfc_pkg::ADDR_CTRL, 1);
        write_reg(dfc_pkg::ADDR_CTRL, 0);
        wait_state("drained");
        check_eq("c_fc_n", c_fc_n, 1);
        report_test("force stop", errs);
    endtask

    task automatic overflow_drop();
        int errs = err_count;
        int rcv_start = rcv_count;
        set_models(0, 1'b1, `DFC_DEPTH + 3);
        wait_state("tx_done");
        // Drop pulse and then the sticky bit
        settle(3);
        expect_reg("status", dfc_pkg::ADDR_STATUS, 1);
        expect_reg("usage", dfc_pkg::ADDR_USAGE,
                   (`DFC_DEPTH > usage_max) ? usage_max : `DFC_DEPTH);
        // Late words never made it in
        while (exp_q.size() > `DFC_DEPTH) begin
            void'(exp_q.pop_back());
        end
        set_models(100, 1'b0, 0);
        wait_state("drained");
        check_eq("words received", rcv_count - rcv_start, `DFC_DEPTH);
        write_reg(dfc_pkg::ADDR_STATUS, 1);
        expect_reg("status", dfc_pkg::ADDR_STATUS, 0);
        report_test("overflow", errs);
    endtask

    task automatic apb_error_access();
        int errs = err_count;
        logic [31:0] rd;
        logic        err;
        bus_transfer(1'b0, 8'h10, '0, rd, err);
        check_eq("pslverr", err, 1);
        check_eq("prdata", rd, 0);
        bus_transfer(1'b1, 8'h10, 32'h1, rd, err);
        check_eq("pslverr", err, 1);
        // Unmapped write must not reach CTRL
        expect_reg("ctrl", dfc_pkg::ADDR_CTRL, 0);
        report_test("apb error", errs);
    endtask

`endif

// ==== dv/dfc_rx_tb.sv ====
// Testbench for the delayed-flow-control receiver.
// Models the link transmitter with its round-trip delay, a random-ready
// consumer and an in-order scoreboard. Directed tests come from the header.
`timescale 1ns/1ps
`include "dfc_params.svh"

module dfc_rx_tb;

    logic               clk = 1'b0;
    logic               rst;
    logic               c_vld;
    dfc_pkg::dfc_word_t c_data;
    logic               c_fc_n;
    logic               p_srdy;
    logic               p_drdy;
    dfc_pkg::dfc_word_t p_data;
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic [7:0]         paddr;
    logic [31:0]        pwdata;
    logic [31:0]        prdata;
    logic               pready;
    logic               pslverr;

    // ------------------------------
    // Model state
    // ------------------------------

    // c_fc_n as seen by the far end with the oldest at the top
    logic               fc_line [`DFC_RT_LAT];
    int                 tx_remaining = 0;
    int                 tx_sent = 0;
    int                 rcv_count = 0;
    int                 drdy_pct = 100;
    bit                 ignore_fc = 1'b0;
    dfc_pkg::dfc_word_t tx_next;
    dfc_pkg::dfc_word_t exp_q [$];
    dfc_pkg::dfc_word_t exp_head;
    int                 err_count = 0;
    int                 tests_run = 0;
    int                 tests_failed = 0;

    dfc_rx_top i_dut (.*);

    `include "dfc_rx_tests.svh"

    always #5 clk = ~clk;

    // Transmitter and consumer drive 1 ns after the rising edge
    always @(posedge clk) begin
        #1;
        for (int i = `DFC_RT_LAT - 1; i > 0; i--) begin
            fc_line[i] = fc_line[i-1];
        end
        fc_line[0] = c_fc_n;
        // Send only on a delayed go unless told to ignore it
        if (tx_remaining > 0 && (fc_line[`DFC_RT_LAT-1] || ignore_fc)) begin
            c_vld  = 1'b1;
            c_data = tx_next;
            exp_q.push_back(tx_next);
            tx_next++;
            tx_remaining--;
            tx_sent++;
        end else begin
            c_vld = 1'b0;
        end
        p_drdy = ($urandom_range(99) < drdy_pct);
    end

    // Scoreboard samples mid-cycle where the consumer port is stable
    always @(negedge clk) begin
        if (!rst && p_srdy && p_drdy) begin
            assert (exp_q.size() > 0) else begin
                $display("Word %h came out with nothing outstanding at %0t", p_data, $time);
                err_count++;
            end
            if (exp_q.size() > 0) begin
                exp_head = exp_q.pop_front();
                check_eq("p_data", p_data, exp_head);
                rcv_count++;
            end
        end
    end

    // Hard stop for a run that never completes
    initial begin
        #1_000_000;
        $display("Run stopped by the global time limit at %0t", $time);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        void'($urandom(32'h990d));
        rst     = 1'b1;
        c_vld   = 1'b0;
        c_data  = '0;
        p_drdy  = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        for (int i = 0; i < `DFC_RT_LAT; i++) begin
            fc_line[i] = 1'b0;
        end
        tx_next = dfc_pkg::dfc_word_t'($urandom);

        reset_state_check();
        stream_backpressure();
        threshold_flow();
        force_stop_hold();
        overflow_drop();
        apb_error_access();

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+verilog
+incdir+dv
verilog/dfc_pkg.sv
verilog/dfc_fifo_wr_if.sv
verilog/dfc_rx_ctl.sv
verilog/dfc_rx_fifo.sv
verilog/dfc_rx_csr.sv
verilog/dfc_rx_top.sv
dv/dfc_rx_tb.sv
